/* masku_settings.svh */
// Mask unit settings: word width, vector-length width and popcount width macros

`ifndef MASKU_SETTINGS_SVH
`define MASKU_SETTINGS_SVH

// Operand and result word width
// One beat carries one word of each operand
`define MASKU_WORD_W 64

// Vector length in bits of mask
// 10 bits hold vl up to 512, so at most 8 beats per instruction
`define MASKU_VL_W 10

// Popcount and scalar result width
// Must hold the largest vl, since every bit below vl may be set
`define MASKU_CNT_W 10

`endif

/* masku_pkg.sv */
// Mask unit package: opcode enum and the word, length and count types

`include "masku_settings.svh"

package masku_pkg;

  // One operand or result word
  typedef logic [`MASKU_WORD_W-1:0] word_t;

  // Vector length, also used for the remaining-bit count
  typedef logic [`MASKU_VL_W-1:0] vl_t;

  // Popcount and scalar result
  typedef logic [`MASKU_CNT_W-1:0] cnt_t;

  // Mask instructions handled by the unit
  // Logical ops first, popcount last
  typedef enum logic [3:0] {
    VMAND  = 4'd0,
    VMNAND = 4'd1,
    VMANDN = 4'd2,
    VMXOR  = 4'd3,
    VMOR   = 4'd4,
    VMNOR  = 4'd5,
    VMORN  = 4'd6,
    VMXNOR = 4'd7,
    VCPOP  = 4'd8
  } masku_op_e;

endpackage

/* masku_sequencer.sv */
// Mask unit stage 1: active instruction, remaining-bit count, per-beat bit enable and last flag

`timescale 1ns/1ps

`include "masku_settings.svh"

module masku_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command strobe
  input  logic                 cmd_valid_i,
  input  masku_pkg::masku_op_e cmd_op_i,
  input  masku_pkg::vl_t       cmd_vl_i,
  input  logic                 cmd_vm_i,
  // Operand beat strobe
  input  logic                 beat_valid_i,
  input  masku_pkg::word_t     beat_vs2_i,
  input  masku_pkg::word_t     beat_vs1_i,
  input  masku_pkg::word_t     beat_vd_i,
  input  masku_pkg::word_t     beat_v0_i,
  // End of instruction, from stage 3
  input  logic                 retire_i,
  output logic                 active_o,
  // Stage 1 to stage 2
  output logic                 s1_valid_o,
  output masku_pkg::masku_op_e s1_op_o,
  output logic                 s1_vm_o,
  output masku_pkg::word_t     s1_vs2_o,
  output masku_pkg::word_t     s1_vs1_o,
  output masku_pkg::word_t     s1_vd_o,
  output masku_pkg::word_t     s1_v0_o,
  output masku_pkg::word_t     s1_en_o,
  output logic                 s1_last_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction state
  ////////////////////////////////////////////////////////////////////////////

  masku_pkg::masku_op_e op_q;
  logic                 vm_q;
  masku_pkg::vl_t       remain_q;
  logic                 active_q;

  // Only one instruction at a time, and vl of zero has nothing to do
  logic cmd_take;
  assign cmd_take = cmd_valid_i && !active_q && (cmd_vl_i != '0);

  // Beats past the end of the vector are dropped
  logic beat_take;
  assign beat_take = beat_valid_i && active_q && (remain_q != '0);

  // Full word left, or only a partial tail
  logic full_word;
  assign full_word = remain_q >= masku_pkg::vl_t'(`MASKU_WORD_W);

  masku_pkg::word_t en_d;
  masku_pkg::vl_t   remain_d;

  always_comb begin
    if (full_word) begin
      en_d     = '1;
      remain_d = remain_q - masku_pkg::vl_t'(`MASKU_WORD_W);
    end else begin
      // Low remain_q bits set, the tail keeps vd
      en_d     = (masku_pkg::word_t'(1) << remain_q) - masku_pkg::word_t'(1);
      remain_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      remain_q <= '0;
    end else if (cmd_take) begin
      active_q <= 1'b1;
      remain_q <= cmd_vl_i;
    end else begin
      if (retire_i) begin
        active_q <= 1'b0;
      end
      if (beat_take) begin
        remain_q <= remain_d;
      end
    end
  end

  // Command fields, held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      op_q <= cmd_op_i;
      vm_q <= cmd_vm_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= beat_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_take) begin
      s1_op_o   <= op_q;
      s1_vm_o   <= vm_q;
      s1_vs2_o  <= beat_vs2_i;
      s1_vs1_o  <= beat_vs1_i;
      s1_vd_o   <= beat_vd_i;
      s1_v0_o   <= beat_v0_i;
      s1_en_o   <= en_d;
      // Last once nothing remains after this beat
      s1_last_o <= !full_word || (remain_d == '0);
    end
  end

  assign active_o = active_q;

endmodule

/* masku_logic_alu.sv */
// Mask unit stage 2: logical mask ops with tail merge, and the word to count for vcpop

`timescale 1ns/1ps

module masku_logic_alu (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From stage 1
  input  logic                 s1_valid_i,
  input  masku_pkg::masku_op_e s1_op_i,
  input  logic                 s1_vm_i,
  input  masku_pkg::word_t     s1_vs2_i,
  input  masku_pkg::word_t     s1_vs1_i,
  input  masku_pkg::word_t     s1_vd_i,
  input  masku_pkg::word_t     s1_v0_i,
  input  masku_pkg::word_t     s1_en_i,
  input  logic                 s1_last_i,
  // To stage 3
  output logic                 s2_valid_o,
  output logic                 s2_cpop_o,
  output masku_pkg::word_t     s2_word_o,
  output logic                 s2_last_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Mask ALU
  ////////////////////////////////////////////////////////////////////////////

  masku_pkg::word_t op_res;
  masku_pkg::word_t pred;
  masku_pkg::word_t word_d;
  logic             is_cpop;

  assign is_cpop = (s1_op_i == masku_pkg::VCPOP);

  // Raw logical result on vs2 and vs1
  always_comb begin
    unique case (s1_op_i)
      masku_pkg::VMAND:  op_res = s1_vs2_i & s1_vs1_i;
      masku_pkg::VMNAND: op_res = ~(s1_vs2_i & s1_vs1_i);
      masku_pkg::VMANDN: op_res = s1_vs2_i & ~s1_vs1_i;
      masku_pkg::VMXOR:  op_res = s1_vs2_i ^ s1_vs1_i;
      masku_pkg::VMOR:   op_res = s1_vs2_i | s1_vs1_i;
      masku_pkg::VMNOR:  op_res = ~(s1_vs2_i | s1_vs1_i);
      masku_pkg::VMORN:  op_res = s1_vs2_i | ~s1_vs1_i;
      masku_pkg::VMXNOR: op_res = ~(s1_vs2_i ^ s1_vs1_i);
      default:           op_res = '0;
    endcase
  end

  // Bits taking part in the popcount
  // vm low means v0 masks them further
  assign pred = s1_en_i & (s1_vm_i ? '1 : s1_v0_i);

  always_comb begin
    if (is_cpop) begin
      word_d = s1_vs2_i & pred;
    end else begin
      // Tail undisturbed, bits at vl and above keep old vd
      word_d = (op_res & s1_en_i) | (s1_vd_i & ~s1_en_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2 output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s2_valid_o <= 1'b0;
    end else begin
      s2_valid_o <= s1_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_i) begin
      s2_cpop_o <= is_cpop;
      s2_word_o <= word_d;
      s2_last_o <= s1_last_i;
    end
  end

endmodule

/* masku_popcount_acc.sv */
// Mask unit stage 3: result forwarding, popcount accumulation and scalar output

`timescale 1ns/1ps

`include "masku_settings.svh"

module masku_popcount_acc (
  input  logic             clk_i,
  input  logic             rst_ni,
  // From stage 2
  input  logic             s2_valid_i,
  input  logic             s2_cpop_i,
  input  masku_pkg::word_t s2_word_i,
  input  logic             s2_last_i,
  // Logical op results
  output logic             res_valid_o,
  output masku_pkg::word_t res_word_o,
  output logic             res_last_o,
  // vcpop scalar
  output logic             scalar_valid_o,
  output masku_pkg::cnt_t  scalar_o,
  // Back to the sequencer
  output logic             retire_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Popcount
  ////////////////////////////////////////////////////////////////////////////

  masku_pkg::cnt_t pop;
  masku_pkg::cnt_t acc_q;
  masku_pkg::cnt_t total;

  // Set bits of this word, already trimmed to vl and v0 by stage 2
  always_comb begin
    pop = '0;
    for (int i = 0; i < `MASKU_WORD_W; i++) begin
      pop = pop + masku_pkg::cnt_t'(s2_word_i[i]);
    end
  end

  assign total = acc_q + pop;

  logic cpop_beat;
  logic word_beat;
  assign cpop_beat = s2_valid_i && s2_cpop_i;
  assign word_beat = s2_valid_i && !s2_cpop_i;

  ////////////////////////////////////////////////////////////////////////////
  // Output register and accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q          <= '0;
      res_valid_o    <= 1'b0;
      res_last_o     <= 1'b0;
      scalar_valid_o <= 1'b0;
    end else begin
      res_valid_o    <= word_beat;
      res_last_o     <= word_beat && s2_last_i;
      scalar_valid_o <= cpop_beat && s2_last_i;
      if (cpop_beat) begin
        // Sum restarts for the next instruction
        acc_q <= s2_last_i ? '0 : total;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_beat) begin
      res_word_o <= s2_word_i;
    end
    if (cpop_beat && s2_last_i) begin
      scalar_o <= total;
    end
  end

  // Raised while the last output is being loaded
  // so the sequencer goes idle at the same edge that outputs it
  assign retire_o = s2_valid_i && s2_last_i;

endmodule

/* masku_top.sv */
// Mask unit top level: three-stage pipeline of sequencer, mask ALU and popcount accumulator

`timescale 1ns/1ps

module masku_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command strobe
  input  logic                 cmd_valid_i,
  input  masku_pkg::masku_op_e cmd_op_i,
  input  masku_pkg::vl_t       cmd_vl_i,
  input  logic                 cmd_vm_i,
  // Operand beat strobe
  input  logic                 beat_valid_i,
  input  masku_pkg::word_t     beat_vs2_i,
  input  masku_pkg::word_t     beat_vs1_i,
  input  masku_pkg::word_t     beat_vd_i,
  input  masku_pkg::word_t     beat_v0_i,
  // Logical op results
  output logic                 res_valid_o,
  output masku_pkg::word_t     res_word_o,
  output logic                 res_last_o,
  // vcpop scalar
  output logic                 scalar_valid_o,
  output masku_pkg::cnt_t      scalar_o,
  // Instruction in progress
  output logic                 busy_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Stage signals
  ////////////////////////////////////////////////////////////////////////////

  logic                 active;
  logic                 retire;

  logic                 s1_valid;
  masku_pkg::masku_op_e s1_op;
  logic                 s1_vm;
  masku_pkg::word_t     s1_vs2;
  masku_pkg::word_t     s1_vs1;
  masku_pkg::word_t     s1_vd;
  masku_pkg::word_t     s1_v0;
  masku_pkg::word_t     s1_en;
  logic                 s1_last;

  logic                 s2_valid;
  logic                 s2_cpop;
  masku_pkg::word_t     s2_word;
  logic                 s2_last;

  // Stage 1, command and beat bookkeeping
  masku_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_vl_i     (cmd_vl_i),
    .cmd_vm_i     (cmd_vm_i),
    .beat_valid_i (beat_valid_i),
    .beat_vs2_i   (beat_vs2_i),
    .beat_vs1_i   (beat_vs1_i),
    .beat_vd_i    (beat_vd_i),
    .beat_v0_i    (beat_v0_i),
    .retire_i     (retire),
    .active_o     (active),
    .s1_valid_o   (s1_valid),
    .s1_op_o      (s1_op),
    .s1_vm_o      (s1_vm),
    .s1_vs2_o     (s1_vs2),
    .s1_vs1_o     (s1_vs1),
    .s1_vd_o      (s1_vd),
    .s1_v0_o      (s1_v0),
    .s1_en_o      (s1_en),
    .s1_last_o    (s1_last)
  );

  // Stage 2, logical ops or word to count
  masku_logic_alu u_logic_alu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .s1_valid_i (s1_valid),
    .s1_op_i    (s1_op),
    .s1_vm_i    (s1_vm),
    .s1_vs2_i   (s1_vs2),
    .s1_vs1_i   (s1_vs1),
    .s1_vd_i    (s1_vd),
    .s1_v0_i    (s1_v0),
    .s1_en_i    (s1_en),
    .s1_last_i  (s1_last),
    .s2_valid_o (s2_valid),
    .s2_cpop_o  (s2_cpop),
    .s2_word_o  (s2_word),
    .s2_last_o  (s2_last)
  );

  // Stage 3, outputs and end of instruction
  masku_popcount_acc u_popcount_acc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .s2_valid_i     (s2_valid),
    .s2_cpop_i      (s2_cpop),
    .s2_word_i      (s2_word),
    .s2_last_i      (s2_last),
    .res_valid_o    (res_valid_o),
    .res_word_o     (res_word_o),
    .res_last_o     (res_last_o),
    .scalar_valid_o (scalar_valid_o),
    .scalar_o       (scalar_o),
    .retire_o       (retire)
  );

  // Busy from command accept until the last output leaves stage 3
  assign busy_o = active;

endmodule

/* tb_masku.sv */
// Mask unit testbench: stimulus table, LFSR operands, reference model, output monitor and timeout

`timescale 1ns/1ps

`include "masku_settings.svh"

module tb_masku;

  localparam int NUM_ENTRIES = 12;
  // Roughly 40 cycles per entry at most, plus reset and idle checks
  localparam int CYCLE_LIMIT = 40 * NUM_ENTRIES + 100;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cmd_valid_i;
  masku_pkg::masku_op_e cmd_op_i;
  masku_pkg::vl_t       cmd_vl_i;
  logic                 cmd_vm_i;
  logic                 beat_valid_i;
  masku_pkg::word_t     beat_vs2_i;
  masku_pkg::word_t     beat_vs1_i;
  masku_pkg::word_t     beat_vd_i;
  masku_pkg::word_t     beat_v0_i;
  logic                 res_valid_o;
  masku_pkg::word_t     res_word_o;
  logic                 res_last_o;
  logic                 scalar_valid_o;
  masku_pkg::cnt_t      scalar_o;
  logic                 busy_o;

  int          cycle = 0;
  logic [31:0] lfsr_q;

  // Expected outputs, each with the cycle it must show up in
  masku_pkg::word_t exp_word_q[$];
  logic             exp_last_q[$];
  int               exp_res_cyc_q[$];
  masku_pkg::cnt_t  exp_scalar_q[$];
  int               exp_scalar_cyc_q[$];

  // Op, vl and vm per entry
  masku_pkg::masku_op_e tbl_op [NUM_ENTRIES] = '{
    masku_pkg::VMAND, masku_pkg::VMNAND, masku_pkg::VMANDN, masku_pkg::VMXOR,
    masku_pkg::VMOR,  masku_pkg::VMNOR,  masku_pkg::VMORN,  masku_pkg::VMXNOR,
    masku_pkg::VCPOP, masku_pkg::VCPOP,  masku_pkg::VCPOP,  masku_pkg::VCPOP
  };
  masku_pkg::vl_t tbl_vl [NUM_ENTRIES] = '{
    10'd64, 10'd512, 10'd37, 10'd100, 10'd64, 10'd512, 10'd37, 10'd100,
    10'd512, 10'd100, 10'd37, 10'd512
  };
  logic tbl_vm [NUM_ENTRIES] = '{
    1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0,
    1'b1, 1'b1, 1'b0, 1'b0
  };

  masku_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_vl_i       (cmd_vl_i),
    .cmd_vm_i       (cmd_vm_i),
    .beat_valid_i   (beat_valid_i),
    .beat_vs2_i     (beat_vs2_i),
    .beat_vs1_i     (beat_vs1_i),
    .beat_vd_i      (beat_vd_i),
    .beat_v0_i      (beat_v0_i),
    .res_valid_o    (res_valid_o),
    .res_word_o     (res_word_o),
    .res_last_o     (res_last_o),
    .scalar_valid_o (scalar_valid_o),
    .scalar_o       (scalar_o),
    .busy_o         (busy_o)
  );

  // 100 ns clock period
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_and_stop();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_word(input string name, input masku_pkg::word_t exp,
                            input masku_pkg::word_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      fail_and_stop();
    end
  endtask

  task automatic check_cnt(input string name, input masku_pkg::cnt_t exp,
                           input masku_pkg::cnt_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      fail_and_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      fail_and_stop();
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One step per bit taken
  task automatic rand_word(output masku_pkg::word_t w);
    for (int i = 0; i < `MASKU_WORD_W; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  // Mask logical op on one element
  function automatic logic ref_bit(input masku_pkg::masku_op_e op, input logic a,
                                   input logic b);
    case (op)
      masku_pkg::VMAND:  return a & b;
      masku_pkg::VMNAND: return ~(a & b);
      masku_pkg::VMANDN: return a & ~b;
      masku_pkg::VMXOR:  return a ^ b;
      masku_pkg::VMOR:   return a | b;
      masku_pkg::VMNOR:  return ~(a | b);
      masku_pkg::VMORN:  return a | ~b;
      masku_pkg::VMXNOR: return ~(a ^ b);
      default:           return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Beat with no instruction active, must be dropped
  task automatic drive_idle_beat();
    masku_pkg::word_t w;
    @(posedge clk_i);
    #10;
    rand_word(w);
    beat_valid_i = 1'b1;
    beat_vs2_i   = w;
    beat_vs1_i   = ~w;
    @(posedge clk_i);
    #10;
    beat_valid_i = 1'b0;
    repeat (6) @(posedge clk_i);
    #10;
    check_bit("busy_o", 1'b0, busy_o);
  endtask

  task automatic run_entry(input int e);
    masku_pkg::masku_op_e op;
    masku_pkg::vl_t       vl;
    logic                 vm;
    int                   nbeats;
    int                   idx;
    masku_pkg::word_t     vs2;
    masku_pkg::word_t     vs1;
    masku_pkg::word_t     vd;
    masku_pkg::word_t     v0;
    masku_pkg::word_t     exp_w;
    masku_pkg::cnt_t      cnt;
    op     = tbl_op[e];
    vl     = tbl_vl[e];
    vm     = tbl_vm[e];
    nbeats = (int'(vl) + 63) / 64;
    cnt    = '0;
    @(posedge clk_i);
    #10;
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_vl_i    = vl;
    cmd_vm_i    = vm;
    for (int j = 0; j < nbeats; j++) begin
      @(posedge clk_i);
      #10;
      if (j == 0) begin
        // Busy from the accept edge, and a second command now is dropped
        check_bit("busy_o", 1'b1, busy_o);
        cmd_valid_i = 1'b1;
        cmd_op_i    = masku_pkg::VMAND;
        cmd_vl_i    = 10'd3;
        cmd_vm_i    = !vm;
      end else begin
        cmd_valid_i = 1'b0;
      end
      rand_word(vs2);
      rand_word(vs1);
      rand_word(vd);
      rand_word(v0);
      beat_valid_i = 1'b1;
      beat_vs2_i   = vs2;
      beat_vs1_i   = vs1;
      beat_vd_i    = vd;
      beat_v0_i    = v0;
      // Reference, element by element against vl
      for (int i = 0; i < `MASKU_WORD_W; i++) begin
        idx = j * `MASKU_WORD_W + i;
        if (idx < int'(vl)) begin
          exp_w[i] = ref_bit(op, vs2[i], vs1[i]);
          if (vs2[i] && (vm || v0[i])) begin
            cnt = cnt + masku_pkg::cnt_t'(1);
          end
        end else begin
          exp_w[i] = vd[i];
        end
      end
      // Out three cycles after the beat's own cycle
      if (op != masku_pkg::VCPOP) begin
        exp_word_q.push_back(exp_w);
        exp_last_q.push_back(j == nbeats - 1);
        exp_res_cyc_q.push_back(cycle + 3);
      end else if (j == nbeats - 1) begin
        exp_scalar_q.push_back(cnt);
        exp_scalar_cyc_q.push_back(cycle + 3);
      end
    end
    @(posedge clk_i);
    #10;
    cmd_valid_i  = 1'b0;
    beat_valid_i = 1'b0;
    while (busy_o) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : monitor
    int   exp_cyc;
    logic exp_last;
    if (rst_ni && res_valid_o) begin
      if (exp_word_q.size() == 0) begin
        $display("A result word came out at cycle %0d with none expected", cycle);
        fail_and_stop();
      end else begin
        exp_cyc  = exp_res_cyc_q.pop_front();
        exp_last = exp_last_q.pop_front();
        check_word("res_word_o", exp_word_q.pop_front(), res_word_o);
        check_bit("res_last_o", exp_last, res_last_o);
        // Busy drops on the final output only
        check_bit("busy_o", !exp_last, busy_o);
        if (cycle != exp_cyc) begin
          $display("A result word came out at cycle %0d instead of cycle %0d", cycle, exp_cyc);
          fail_and_stop();
        end
      end
    end
    if (rst_ni && scalar_valid_o) begin
      if (exp_scalar_q.size() == 0) begin
        $display("A scalar came out at cycle %0d with none expected", cycle);
        fail_and_stop();
      end else begin
        exp_cyc = exp_scalar_cyc_q.pop_front();
        check_cnt("scalar_o", exp_scalar_q.pop_front(), scalar_o);
        check_bit("busy_o", 1'b0, busy_o);
        if (cycle != exp_cyc) begin
          $display("A scalar came out at cycle %0d instead of cycle %0d", cycle, exp_cyc);
          fail_and_stop();
        end
      end
    end
  end

  // Cycle counter and timeout
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    lfsr_q       = 32'h0584_e311;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_op_i     = masku_pkg::VMAND;
    cmd_vl_i     = '0;
    cmd_vm_i     = 1'b1;
    beat_valid_i = 1'b0;
    beat_vs2_i   = '0;
    beat_vs1_i   = '0;
    beat_vd_i    = '0;
    beat_v0_i    = '0;
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("res_valid_o", 1'b0, res_valid_o);
    check_bit("scalar_valid_o", 1'b0, scalar_valid_o);
    drive_idle_beat();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_entry(e);
    end
    // Let the monitor see the final output
    repeat (2) @(posedge clk_i);
    if (exp_word_q.size() != 0 || exp_scalar_q.size() != 0) begin
      $display("Expected outputs never came out, %0d words and %0d scalars",
               exp_word_q.size(), exp_scalar_q.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "Missing outputs");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* build.f */
+incdir+.
masku_pkg.sv
masku_sequencer.sv
masku_logic_alu.sv
masku_popcount_acc.sv
masku_top.sv
tb_masku.sv

/* run.sh */
#!/bin/sh
# Build the mask unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_masku -f build.f -o sim_masku

out=$(./obj_dir/sim_masku 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
